// ==== Bender.yml ====
package:
  name: simd_wrapper

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/simd_wrap_pkg.sv
      - rtl/result_fifo.sv
      - rtl/upstream_seq.sv
      - rtl/simd_wrapper.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_simd_wrapper.sv

// ==== build.f ====
+incdir+rtl
rtl/simd_wrap_pkg.sv
rtl/result_fifo.sv
rtl/upstream_seq.sv
rtl/simd_wrapper.sv
tests/tb_simd_wrapper.sv

// ==== rtl/result_fifo.sv ====
module result_fifo #(
  parameter int DEPTH     = 8,
  parameter int THRESHOLD = 6,
  parameter int WIDTH     = 34
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             write,
  input  logic [WIDTH-1:0] write_data,
  output logic             almost_full,
  output logic             head_valid,
  output logic [WIDTH-1:0] head_data,
  input  logic             pop
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] count_t;

  // Storage behind the head stage
  logic [WIDTH-1:0] mem [DEPTH];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  // Total occupancy, head stage included
  count_t           count;
  logic             buf_nonempty;
  logic             load_head;
  logic             full;

  // Circular pointer advance
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Buffer holds something beyond the head entry
  assign buf_nonempty = count > count_t'(head_valid);
  // Refill head when it is empty or being popped
  assign load_head    = (~head_valid | pop) & buf_nonempty;
  assign full         = count == count_t'(DEPTH);
  assign almost_full  = count >= count_t'(THRESHOLD);

  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= write_data;
  end

  // ----------------------------------------
  // Pointers, count and head stage
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
      head_data  <= '0;
    end
    else
    begin
      if (write)
        wr_ptr <= ptr_inc(wr_ptr);
      count <= count + count_t'(write) - count_t'(pop);
      if (load_head)
      begin
        // Next entry shows one cycle after the pop
        head_data  <= mem[rd_ptr];
        head_valid <= 1'b1;
        rd_ptr     <= ptr_inc(rd_ptr);
      end
      else if (pop)
        head_valid <= 1'b0;
    end
  end

  // Writer ignored ready or threshold too close to depth
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) write |-> !full)
    else $error("result_fifo: write into full FIFO");

  // Reader must wait for the head stage
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> head_valid)
    else $error("result_fifo: pop with empty head");

endmodule

// ==== rtl/simd_wrap_defines.svh ====
`ifndef SIMD_WRAP_DEFINES_SVH
`define SIMD_WRAP_DEFINES_SVH

// ----------------------------------------
// Lane geometry
// ----------------------------------------

// Execution lanes feeding the result path
`define SIMD_LANES 4
`define SIMD_LANE_WIDTH 32
// Start and end of stream marks
`define SIMD_CNTL_WIDTH 2
`define SIMD_TAG_WIDTH 8

// ----------------------------------------
// FIFO sizing
// ----------------------------------------

// Threshold leaves slack for words already in flight
`define SIMD_RESULT_FIFO_DEPTH 8
`define SIMD_RESULT_FIFO_THRESHOLD 6
`define SIMD_TAG_FIFO_DEPTH 4
`define SIMD_TAG_FIFO_THRESHOLD 2

`endif

// ==== rtl/simd_wrap_pkg.sv ====
`include "simd_wrap_defines.svh"

package simd_wrap_pkg;

  // ----------------------------------------
  // Plain vector types
  // ----------------------------------------

  // One lane result word
  typedef logic [`SIMD_LANE_WIDTH-1:0] lane_data_t;
  // Control field riding with each word
  typedef logic [`SIMD_CNTL_WIDTH-1:0] lane_cntl_t;
  // Stream operation tag from the PE controller
  typedef logic [`SIMD_TAG_WIDTH-1:0] op_tag_t;
  // One bit per execution lane
  typedef logic [`SIMD_LANES-1:0] lane_mask_t;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------

  // One entry of a lane result FIFO
  typedef struct packed {
    lane_cntl_t cntl;
    lane_data_t data;
  } lane_result_t;

  // Everything presented to the stack upstream interface
  typedef struct packed {
    op_tag_t                        tag;
    lane_mask_t                     valid;
    lane_result_t [`SIMD_LANES-1:0] lanes;
  } upstream_regs_t;

  // Upstream sequencer states
  typedef enum logic [2:0] {
    WAIT,
    SEND,
    WAIT_COMPLETE,
    WAIT_RELEASE,
    DONE
  } upstream_state_e;

endpackage

// ==== rtl/simd_wrapper.sv ====
`include "simd_wrap_defines.svh"

module simd_wrapper (
  input  logic                          clk,
  input  logic                          rst,
  // Results from the stream operation controller
  input  simd_wrap_pkg::lane_mask_t     result_valid,
  input  simd_wrap_pkg::lane_result_t   result [`SIMD_LANES],
  output simd_wrap_pkg::lane_mask_t     result_ready,
  // Tags from the PE controller
  input  logic                          tag_valid,
  input  simd_wrap_pkg::op_tag_t        tag,
  output logic                          tag_ready,
  // Stack upstream interface
  input  logic                          stack_ready,
  input  logic                          stack_complete,
  output simd_wrap_pkg::upstream_regs_t upstream
);

  import simd_wrap_pkg::*;

  lane_mask_t                     lane_almost_full;
  lane_mask_t                     lane_head_valid;
  lane_result_t [`SIMD_LANES-1:0] lane_head;
  logic                           tag_almost_full;
  logic                           tag_head_valid;
  op_tag_t                        tag_head;
  logic                           pop;
  // Stack side inputs after one flop
  logic                           stack_ready_q;
  logic                           stack_complete_q;

  // ----------------------------------------
  // Lane result FIFOs
  // ----------------------------------------
  for (genvar i = 0; i < `SIMD_LANES; i++)
  begin : g_lane
    result_fifo #(
      .DEPTH     (`SIMD_RESULT_FIFO_DEPTH),
      .THRESHOLD (`SIMD_RESULT_FIFO_THRESHOLD),
      .WIDTH     ($bits(lane_result_t))
    ) u_result_fifo (
      .clk         (clk),
      .rst         (rst),
      .write       (result_valid[i]),
      .write_data  (result[i]),
      .almost_full (lane_almost_full[i]),
      .head_valid  (lane_head_valid[i]),
      .head_data   (lane_head[i]),
      .pop         (pop)
    );
  end

  // Controller may send while below threshold
  assign result_ready = ~lane_almost_full;

  // ----------------------------------------
  // Tag FIFO
  // ----------------------------------------
  result_fifo #(
    .DEPTH     (`SIMD_TAG_FIFO_DEPTH),
    .THRESHOLD (`SIMD_TAG_FIFO_THRESHOLD),
    .WIDTH     ($bits(op_tag_t))
  ) u_tag_fifo (
    .clk         (clk),
    .rst         (rst),
    .write       (tag_valid),
    .write_data  (tag),
    .almost_full (tag_almost_full),
    .head_valid  (tag_head_valid),
    .head_data   (tag_head),
    .pop         (pop)
  );

  upstream_seq u_upstream_seq (
    .clk              (clk),
    .rst              (rst),
    .lane_head_valid  (lane_head_valid),
    .tag_head_valid   (tag_head_valid),
    .stack_ready_q    (stack_ready_q),
    .stack_complete_q (stack_complete_q),
    .pop              (pop)
  );

  // ----------------------------------------
  // Input flops and tag ready
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stack_ready_q    <= 1'b0;
      stack_complete_q <= 1'b0;
      tag_ready        <= 1'b0;
    end
    else
    begin
      stack_ready_q    <= stack_ready;
      stack_complete_q <= stack_complete;
      // Follows tag FIFO fill one cycle late
      tag_ready        <= ~tag_almost_full;
    end
  end

  // ----------------------------------------
  // Upstream output register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
      upstream <= '0;
    else if (pop)
    begin
      upstream.tag   <= tag_head;
      upstream.valid <= '1;
      upstream.lanes <= lane_head;
    end
    else
    begin
      // Tag and data hold while only the pulse ends
      upstream.valid <= '0;
    end
  end

  // Each pulse toward the stack lasts exactly one cycle
  a_upstream_pulse: assert property (@(posedge clk) disable iff (rst)
    (|upstream.valid) |=> (upstream.valid == '0))
    else $error("simd_wrapper: upstream valid held longer than one cycle");

endmodule

// ==== rtl/upstream_seq.sv ====
module upstream_seq (
  input  logic                      clk,
  input  logic                      rst,
  input  simd_wrap_pkg::lane_mask_t lane_head_valid,
  input  logic                      tag_head_valid,
  input  logic                      stack_ready_q,
  input  logic                      stack_complete_q,
  output logic                      pop
);

  import simd_wrap_pkg::*;

  upstream_state_e state_q;
  upstream_state_e state_d;
  // Tag and one result in every lane
  logic            all_ready;

  assign all_ready = (&lane_head_valid) & tag_head_valid;

  // ----------------------------------------
  // State register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= WAIT;
    else
      state_q <= state_d;
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      WAIT:
      begin
        // Stack ready is already one cycle old here
        if (all_ready && stack_ready_q)
          state_d = SEND;
      end
      SEND:
      begin
        // Single cycle, output register takes the heads
        state_d = WAIT_COMPLETE;
      end
      WAIT_COMPLETE:
      begin
        if (stack_complete_q)
          state_d = WAIT_RELEASE;
      end
      WAIT_RELEASE:
      begin
        // Hold off until complete drops
        if (!stack_complete_q)
          state_d = DONE;
      end
      DONE:
      begin
        state_d = WAIT;
      end
      default:
      begin
        state_d = WAIT;
      end
    endcase
  end

  // Pops every FIFO together
  assign pop = state_q == SEND;

  // SEND is never held or skipped past the complete wait
  a_send_to_complete: assert property (@(posedge clk) disable iff (rst)
    state_q == SEND |=> state_q == WAIT_COMPLETE)
    else $error("upstream_seq: SEND not followed by WAIT_COMPLETE");

  // All lane FIFOs and the tag FIFO must have a head when popped
  a_pop_heads_valid: assert property (@(posedge clk) disable iff (rst)
    $rose(pop) |-> all_ready)
    else $error("upstream_seq: pop with a missing head");

endmodule

// ==== tests/tb_simd_wrapper.sv ====
`include "simd_wrap_defines.svh"

module tb_simd_wrapper;

  timeunit 1ns;
  timeprecision 100ps;

  import simd_wrap_pkg::*;

  // Five tests of a few dozen sends each plus margin
  localparam int MAX_CYCLES = 2000;
  localparam int THRESHOLD  = `SIMD_RESULT_FIFO_THRESHOLD;

  logic           clk;
  logic           rst;
  lane_mask_t     result_valid;
  lane_result_t   result [`SIMD_LANES];
  lane_mask_t     result_ready;
  logic           tag_valid;
  op_tag_t        tag;
  logic           tag_ready;
  logic           stack_ready;
  logic           stack_complete;
  upstream_regs_t upstream;

  // Scoreboard queues for tags and for each lane
  op_tag_t                        tag_q [$];
  lane_result_t                   lane_q [`SIMD_LANES][$];
  // Queue heads as seen by the checks
  op_tag_t                        exp_tag;
  lane_result_t [`SIMD_LANES-1:0] exp_lanes;
  logic                           exp_avail;
  int                             pulse_cnt;
  // Stack handshake seen since the last pulse
  logic                           seen_complete;
  logic                           released;
  // Phase flags set by the tests
  logic                           hold_window;
  logic                           bp_active;
  int                             bp_fill;
  int                             cycle;
  int                             err_cnt;
  int                             tests_passed;
  int                             tests_failed;
  int                             seed;
  int                             resp_seed;

  simd_wrapper u_dut (
    .clk            (clk),
    .rst            (rst),
    .result_valid   (result_valid),
    .result         (result),
    .result_ready   (result_ready),
    .tag_valid      (tag_valid),
    .tag            (tag),
    .tag_ready      (tag_ready),
    .stack_ready    (stack_ready),
    .stack_complete (stack_complete),
    .upstream       (upstream)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic log_fail(input string msg);
    err_cnt++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // One word on each lane in mask plus an optional tag once ready allows
  task automatic write_op(input lane_mask_t mask, input logic with_tag, input op_tag_t op_tag);
    lane_result_t word;
    @(posedge clk);
    while (!(((result_ready & mask) == mask) && (!with_tag || tag_ready)))
      @(posedge clk);
    for (int i = 0; i < `SIMD_LANES; i++)
    begin
      word.cntl = lane_cntl_t'($random(seed));
      word.data = lane_data_t'($random(seed));
      result[i] <= word;
    end
    result_valid <= mask;
    tag_valid    <= with_tag;
    tag          <= op_tag;
    @(posedge clk);
    result_valid <= '0;
    tag_valid    <= 1'b0;
  endtask

  task automatic wait_pulses(input int target);
    while (pulse_cnt < target)
      @(posedge clk);
  endtask

  // ----------------------------------------
  // Scoreboard and handshake tracking
  // ----------------------------------------
  always @(posedge clk)
  begin : scoreboard
    logic avail;
    if (!rst)
    begin
      // Inputs read here are the values the DUT writes on this edge
      if (tag_valid)
        tag_q.push_back(tag);
      for (int i = 0; i < `SIMD_LANES; i++)
        if (result_valid[i])
          lane_q[i].push_back(result[i]);
      if (upstream.valid[0])
      begin
        if (tag_q.size() > 0)
          void'(tag_q.pop_front());
        for (int i = 0; i < `SIMD_LANES; i++)
          if (lane_q[i].size() > 0)
            void'(lane_q[i].pop_front());
        pulse_cnt     <= pulse_cnt + 1;
        seen_complete <= 1'b0;
        released      <= 1'b0;
      end
      else if (stack_complete)
        seen_complete <= 1'b1;
      else if (seen_complete)
        released <= 1'b1;
    end
    avail = tag_q.size() > 0;
    for (int i = 0; i < `SIMD_LANES; i++)
    begin
      avail = avail && (lane_q[i].size() > 0);
      exp_lanes[i] <= (lane_q[i].size() > 0) ? lane_q[i][0] : '0;
    end
    exp_tag   <= (tag_q.size() > 0) ? tag_q[0] : '0;
    exp_avail <= avail;
    bp_fill   <= lane_q[0].size();
  end

  // Stack side completes each pulse after a short random delay
  initial
  begin : stack_responder
    int unsigned delay;
    forever
    begin
      @(posedge clk);
      if (upstream.valid[0])
      begin
        delay = 1 + ($unsigned($random(resp_seed)) % 4);
        repeat (delay) @(posedge clk);
        stack_complete <= 1'b1;
        repeat (2) @(posedge clk);
        stack_complete <= 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES)
    begin
      $display("timeout: tests did not finish");
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_reset_idle: assert property (@(posedge clk) (rst && cycle != 0) |->
    (upstream == '0 && result_ready == '1))
    else log_fail("upstream or result_ready wrong during reset");

  // tag_ready comes up one cycle after release
  a_reset_release: assert property (@(posedge clk) $fell(rst) |->
    (upstream.valid == '0 && result_ready == '1 && !tag_ready) ##1 tag_ready)
    else log_fail("outputs wrong right after reset release");

  a_pulse_expected: assert property (@(posedge clk) upstream.valid[0] |-> exp_avail)
    else log_fail("upstream pulse with no queued operation");

  a_pulse_all_lanes: assert property (@(posedge clk) (|upstream.valid) |-> (&upstream.valid))
    else log_fail("upstream lane valids not all high together");

  a_pulse_values: assert property (@(posedge clk) upstream.valid[0] |->
    (upstream.tag == exp_tag && upstream.lanes == exp_lanes))
    else log_fail("upstream tag or lane data differ from queue heads");

  // Stack must complete and release between pulses
  a_pulse_pacing: assert property (@(posedge clk) (upstream.valid[0] && pulse_cnt != 0) |->
    released)
    else log_fail("pulse before stack_complete rose and fell");

  a_hold_no_pulse: assert property (@(posedge clk) hold_window |-> !upstream.valid[0])
    else log_fail("pulse sent while it had to be held back");

  a_ready_threshold: assert property (@(posedge clk) bp_active |->
    (result_ready[0] == (bp_fill < THRESHOLD)))
    else log_fail("lane 0 ready does not match its fill level");

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    int errs;
    int n;
    seed           = 97;
    resp_seed      = 97;
    rst            = 1'b1;
    result_valid   = '0;
    foreach (result[i])
      result[i] = '0;
    tag_valid      = 1'b0;
    tag            = '0;
    stack_ready    = 1'b0;
    stack_complete = 1'b0;
    pulse_cnt      = 0;
    seen_complete  = 1'b0;
    released       = 1'b0;
    hold_window    = 1'b0;
    bp_active      = 1'b0;
    cycle          = 0;
    err_cnt        = 0;
    tests_passed   = 0;
    tests_failed   = 0;

    errs = err_cnt;
    repeat (10) @(posedge clk);
    rst         <= 1'b0;
    stack_ready <= 1'b1;
    repeat (3) @(posedge clk);
    end_test("reset", errs);

    errs = err_cnt;
    write_op('1, 1'b1, op_tag_t'($random(seed)));
    wait_pulses(1);
    // Quiet stretch catches a repeated pulse
    repeat (10) @(posedge clk);
    end_test("single transfer", errs);

    errs = err_cnt;
    for (n = 0; n < 20; n++)
      write_op('1, 1'b1, op_tag_t'($random(seed)));
    wait_pulses(21);
    end_test("ordering and pacing", errs);

    errs = err_cnt;
    write_op(4'b0111, 1'b1, op_tag_t'($random(seed)));
    hold_window <= 1'b1;
    repeat (30) @(posedge clk);
    hold_window <= 1'b0;
    write_op(4'b1000, 1'b0, '0);
    wait_pulses(22);
    end_test("missing lane", errs);

    errs = err_cnt;
    @(posedge clk);
    stack_ready <= 1'b0;
    repeat (2) @(posedge clk);
    // A complete operation must wait while the stack is not ready
    hold_window <= 1'b1;
    bp_active   <= 1'b1;
    write_op('1, 1'b1, op_tag_t'($random(seed)));
    n = 1;
    @(posedge clk);
    // Lane 0 alone keeps filling
    while (result_ready[0] && n < `SIMD_RESULT_FIFO_DEPTH)
    begin
      write_op(4'b0001, 1'b0, '0);
      n++;
      @(posedge clk);
    end
    a_bp_count: assert (n == THRESHOLD)
      else log_fail("lane 0 ready dropped at the wrong word count");
    hold_window <= 1'b0;
    bp_active   <= 1'b0;
    stack_ready <= 1'b1;
    // Other lanes and tags catch up while lane 0 drains in order
    for (n = 1; n < THRESHOLD; n++)
      write_op(4'b1110, 1'b1, op_tag_t'($random(seed)));
    wait_pulses(22 + THRESHOLD);
    repeat (10) @(posedge clk);
    end_test("back-pressure", errs);

    $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
      tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
